//--- matvec.f
+incdir+sim
rtl/matvec_dims_pkg.sv
rtl/matvec_ctrl_pkg.sv
rtl/matvec_sequencer.sv
rtl/weight_bank.sv
rtl/vector_store.sv
rtl/mac_array.sv
rtl/matvec_top.sv
sim/matvec_tb.sv

//--- Bender.yml
package:
  name: matvec

sources:
  - files:
      - rtl/matvec_dims_pkg.sv
      - rtl/matvec_ctrl_pkg.sv
      - rtl/matvec_sequencer.sv
      - rtl/weight_bank.sv
      - rtl/vector_store.sv
      - rtl/mac_array.sv
      - rtl/matvec_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/matvec_tb.sv

//--- sim/matvec_tb_tasks.svh
// Stimulus, checking, LFSR and reference model tasks of the multiplier testbench
// Included inside the testbench module body
`ifndef MATVEC_TB_TASKS_SVH
`define MATVEC_TB_TASKS_SVH

// Inputs change just after the rising edge
task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic data_t rand_data();
	data_t v;
	for (int i = 0; i < DATA_W; i++) begin
		v[i] = lfsr_bit();
	end
	return v;
endfunction

task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
	if (expected !== actual) begin
		$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
		value_errors++;
	end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	if (expected !== actual) begin
		$display("Fail %s: expected %b, actual %b", name, expected, actual);
		value_errors++;
	end
endtask

// Row sums in column order, clamped after every step
function automatic acc_t model_row(input int r);
	longint sum;
	sum = 0;
	for (int c = 0; c < N_COLS; c++) begin
		sum = sum + longint'(w_mat[r][c]) * longint'(x_vec[c]);
		if (sum > longint'(ACC_MAX)) begin
			sum = longint'(ACC_MAX);
		end else if (sum < longint'(ACC_MIN)) begin
			sum = longint'(ACC_MIN);
		end
	end
	return acc_t'(sum);
endfunction

task automatic fill_expected();
	for (int r = 0; r < N_ROWS; r++) begin
		exp_res[r] = model_row(r);
	end
endtask

task automatic send_word(input data_t word, input logic first_new);
	int waited;
	waited      = 0;
	input_valid = 1'b1;
	input_data  = word;
	new_matrix  = first_new;
	while (!input_ready && waited < IN_TIMEOUT) begin
		next_cycle();
		waited++;
	end
	if (!input_ready) begin
		$display("Timeout: input_ready stayed low for %0d cycles", IN_TIMEOUT);
		timeout_errors++;
	end
	next_cycle();
	input_valid = 1'b0;
	new_matrix  = 1'b0;
endtask

// new_matrix only on the first weight word
task automatic send_matrix();
	for (int r = 0; r < N_ROWS; r++) begin
		for (int c = 0; c < N_COLS; c++) begin
			send_word(w_mat[r][c], (r == 0) && (c == 0));
		end
	end
endtask

task automatic send_vector();
	for (int c = 0; c < N_COLS; c++) begin
		send_word(x_vec[c], 1'b0);
	end
endtask

task automatic collect_results(input string name, input bit stall);
	int   row;
	int   waited;
	acc_t held;
	logic holding;
	row     = 0;
	waited  = 0;
	holding = 1'b0;
	while (row < N_ROWS && waited < OUT_TIMEOUT) begin
		output_ready = stall ? lfsr_bit() : 1'b1;
		check_bit({name, " input_ready busy"}, 1'b0, input_ready);
		if (output_valid) begin
			// Stalled result must not move
			if (holding) begin
				check_acc($sformatf("%s hold row %0d", name, row), held, output_data);
			end
			if (output_ready) begin
				check_acc($sformatf("%s row %0d", name, row), exp_res[row], output_data);
				row++;
				holding = 1'b0;
			end else begin
				held    = output_data;
				holding = 1'b1;
			end
		end
		next_cycle();
		waited++;
	end
	output_ready = 1'b0;
	if (row < N_ROWS) begin
		$display("Timeout: %s got only %0d of %0d results", name, row, N_ROWS);
		timeout_errors++;
	end
	check_bit({name, " output_valid after stream"}, 1'b0, output_valid);
	check_bit({name, " input_ready after stream"}, 1'b1, input_ready);
endtask

task automatic run_and_check(input string name, input bit load_weights, input bit stall);
	if (load_weights) begin
		send_matrix();
	end
	send_vector();
	collect_results(name, stall);
endtask

`endif

//--- sim/matvec_tb.sv
// Directed testbench for the 8x8 matrix-vector multiplier
// Loads matrices and vectors, then checks the streamed row results
`timescale 1ns/1ps

module matvec_tb;
	import matvec_dims_pkg::*;

	localparam int IN_TIMEOUT  = 50;
	localparam int OUT_TIMEOUT = 400;

	logic  clk;
	logic  reset;
	logic  input_valid;
	logic  input_ready;
	data_t input_data;
	logic  new_matrix;
	logic  output_valid;
	logic  output_ready;
	acc_t  output_data;

	// Software copy of what the DUT holds
	data_t w_mat [N_ROWS][N_COLS];
	data_t x_vec [N_COLS];
	acc_t  exp_res [N_ROWS];

	logic [31:0] lfsr_state;
	int          value_errors;
	int          timeout_errors;

	matvec_top UUT (
		.clk          (clk),
		.reset        (reset),
		.input_valid  (input_valid),
		.input_ready  (input_ready),
		.input_data   (input_data),
		.new_matrix   (new_matrix),
		.output_valid (output_valid),
		.output_ready (output_ready),
		.output_data  (output_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	`include "matvec_tb_tasks.svh"

	task automatic test_identity();
		for (int r = 0; r < N_ROWS; r++) begin
			for (int c = 0; c < N_COLS; c++) begin
				w_mat[r][c] = (r == c) ? data_t'(1) : data_t'(0);
			end
		end
		for (int c = 0; c < N_COLS; c++) begin
			x_vec[c] = rand_data();
		end
		// Each row picks out one vector entry, sign-extended
		for (int r = 0; r < N_ROWS; r++) begin
			exp_res[r] = acc_t'(x_vec[r]);
		end
		run_and_check("identity", 1'b1, 1'b0);
	endtask

	task automatic test_random(input string name, input bit stall);
		for (int r = 0; r < N_ROWS; r++) begin
			for (int c = 0; c < N_COLS; c++) begin
				w_mat[r][c] = rand_data();
			end
		end
		for (int c = 0; c < N_COLS; c++) begin
			x_vec[c] = rand_data();
		end
		fill_expected();
		run_and_check(name, 1'b1, stall);
	endtask

	// New vector only, weights stay from the previous load
	task automatic test_weight_reuse();
		for (int c = 0; c < N_COLS; c++) begin
			x_vec[c] = rand_data();
		end
		fill_expected();
		run_and_check("weight_reuse", 1'b0, 1'b0);
	endtask

	task automatic test_saturation();
		// Top rows overflow positive, bottom rows negative
		for (int r = 0; r < N_ROWS; r++) begin
			for (int c = 0; c < N_COLS; c++) begin
				w_mat[r][c] = (r < N_ROWS / 2) ? data_t'(-8192) : data_t'(8191);
			end
			exp_res[r] = (r < N_ROWS / 2) ? ACC_MAX : ACC_MIN;
		end
		for (int c = 0; c < N_COLS; c++) begin
			x_vec[c] = data_t'(-8192);
		end
		run_and_check("saturation", 1'b1, 1'b0);
	endtask

	initial begin
		reset          = 1'b1;
		input_valid    = 1'b0;
		input_data     = '0;
		new_matrix     = 1'b0;
		output_ready   = 1'b0;
		lfsr_state     = 32'hd026;
		value_errors   = 0;
		timeout_errors = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		next_cycle();

		check_bit("reset output_valid", 1'b0, output_valid);
		check_bit("reset input_ready", 1'b1, input_ready);
		test_identity();
		test_random("random", 1'b0);
		test_weight_reuse();
		test_saturation();
		test_random("back_pressure", 1'b1);

		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/matvec_top.sv
// Top level of the 8x8 matrix-vector multiplier
// Connects the sequencer, the weight and vector stores and the MAC array
`timescale 1ns/1ps

module matvec_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   input_valid,
	output logic                   input_ready,
	input  matvec_dims_pkg::data_t input_data,
	input  logic                   new_matrix,
	output logic                   output_valid,
	input  logic                   output_ready,
	output matvec_dims_pkg::acc_t  output_data
);
	import matvec_dims_pkg::*;
	import matvec_ctrl_pkg::*;

	store_write_t             store_wr;
	column_read_t             col_rd;
	data_t [N_ROWS-1:0]       weight_col;
	data_t                    vector_elem;
	logic                     results_done;

	matvec_sequencer u_sequencer (
		.clk          (clk),
		.reset        (reset),
		.input_valid  (input_valid),
		.new_matrix   (new_matrix),
		.input_data   (input_data),
		.input_ready  (input_ready),
		.results_done (results_done),
		.store_wr     (store_wr),
		.col_rd       (col_rd)
	);

	weight_bank u_weight_bank (
		.clk        (clk),
		.store_wr   (store_wr),
		.col_rd     (col_rd),
		.weight_col (weight_col)
	);

	vector_store u_vector_store (
		.clk         (clk),
		.store_wr    (store_wr),
		.col_rd      (col_rd),
		.vector_elem (vector_elem)
	);

	mac_array u_mac_array (
		.clk          (clk),
		.reset        (reset),
		.col_rd       (col_rd),
		.weight_col   (weight_col),
		.vector_elem  (vector_elem),
		.output_ready (output_ready),
		.output_valid (output_valid),
		.output_data  (output_data),
		.results_done (results_done)
	);

endmodule

//--- rtl/mac_array.sv
// Eight parallel multiply-accumulate lanes, one per matrix row
// Results are streamed out in row order once the last column is summed
`timescale 1ns/1ps

module mac_array (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  matvec_ctrl_pkg::column_read_t                        col_rd,
	input  matvec_dims_pkg::data_t [matvec_dims_pkg::N_ROWS-1:0] weight_col,
	input  matvec_dims_pkg::data_t                               vector_elem,
	input  logic                                                 output_ready,
	output logic                                                 output_valid,
	output matvec_dims_pkg::acc_t                                output_data,
	output logic                                                 results_done
);
	import matvec_dims_pkg::*;
	import matvec_ctrl_pkg::*;

	// Memory read plus the multiplier stages
	localparam int DLY = 1 + MULT_STAGES;

	logic [DLY-1:0] valid_dly;
	logic [DLY-1:0] first_dly;
	logic [DLY-1:0] last_dly;
	acc_t           lane_acc [N_ROWS];
	row_t           out_row;

	// Clamp when both operands share a sign and the sum flips it
	function automatic acc_t sat_add(acc_t a, acc_t b);
		acc_t sum;
		sum = a + b;
		if ((a[ACC_W-1] == b[ACC_W-1]) && (sum[ACC_W-1] != a[ACC_W-1])) begin
			sum = a[ACC_W-1] ? ACC_MIN : ACC_MAX;
		end
		return sum;
	endfunction

	// Column flags follow the data through memory and multiplier
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_dly <= '0;
			first_dly <= '0;
			last_dly  <= '0;
		end else begin
			valid_dly <= {valid_dly[DLY-2:0], col_rd.valid};
			first_dly <= {first_dly[DLY-2:0], col_rd.first};
			last_dly  <= {last_dly[DLY-2:0], col_rd.last};
		end
	end

	for (genvar r = 0; r < N_ROWS; r++) begin : g_lane
		data_t w;
		acc_t  prod_q [MULT_STAGES];
		acc_t  acc_q;

		assign w = weight_col[r];

		always_ff @(posedge clk) begin
			prod_q[0] <= w * vector_elem;
			for (int s = 1; s < MULT_STAGES; s++) begin
				prod_q[s] <= prod_q[s-1];
			end
			// first column restarts the sum
			if (valid_dly[DLY-1]) begin
				if (first_dly[DLY-1]) begin
					acc_q <= prod_q[MULT_STAGES-1];
				end else begin
					acc_q <= sat_add(acc_q, prod_q[MULT_STAGES-1]);
				end
			end
		end

		assign lane_acc[r] = acc_q;
	end

	// Output stream walks the rows, holding under back-pressure
	always_ff @(posedge clk) begin
		if (reset) begin
			output_valid <= 1'b0;
			out_row      <= '0;
		end else if (valid_dly[DLY-1] && last_dly[DLY-1]) begin
			output_valid <= 1'b1;
			out_row      <= '0;
		end else if (output_valid && output_ready) begin
			if (out_row == row_t'(N_ROWS - 1)) begin
				output_valid <= 1'b0;
			end else begin
				out_row <= out_row + 1'b1;
			end
		end
	end

	assign output_data  = lane_acc[out_row];
	assign results_done = output_valid && output_ready && (out_row == row_t'(N_ROWS - 1));

endmodule

//--- rtl/vector_store.sv
// Input vector storage with a single registered read port
// Its one output is shared by every MAC lane
`timescale 1ns/1ps

module vector_store (
	input  logic                          clk,
	input  matvec_ctrl_pkg::store_write_t store_wr,
	input  matvec_ctrl_pkg::column_read_t col_rd,
	output matvec_dims_pkg::data_t        vector_elem
);
	import matvec_dims_pkg::*;

	data_t mem [N_COLS];
	col_t  wr_addr;

	// Vector words only use the low bits of the count
	assign wr_addr = col_t'(store_wr.index.flat);

	always_ff @(posedge clk) begin
		if (store_wr.vector_we) begin
			mem[wr_addr] <= store_wr.data;
		end
		if (col_rd.valid) begin
			vector_elem <= mem[col_rd.col];
		end
	end

endmodule

//--- rtl/weight_bank.sv
// Weight matrix storage, one memory per row
// All rows read the same column together to feed the eight MAC lanes
`timescale 1ns/1ps

module weight_bank (
	input  logic                                                 clk,
	input  matvec_ctrl_pkg::store_write_t                        store_wr,
	input  matvec_ctrl_pkg::column_read_t                        col_rd,
	output matvec_dims_pkg::data_t [matvec_dims_pkg::N_ROWS-1:0] weight_col
);
	import matvec_dims_pkg::*;

	row_t wr_row;
	col_t wr_col;

	// Bank view of the flat word count
	assign wr_row = store_wr.index.rc.row;
	assign wr_col = store_wr.index.rc.col;

	for (genvar r = 0; r < N_ROWS; r++) begin : g_row
		data_t mem [N_COLS];
		data_t rd_q;
		logic  row_we;

		assign row_we = store_wr.weight_we && (wr_row == row_t'(r));

		always_ff @(posedge clk) begin
			if (row_we) begin
				mem[wr_col] <= store_wr.data;
			end
			// Read data shows up one cycle after the request
			if (col_rd.valid) begin
				rd_q <= mem[col_rd.col];
			end
		end

		assign weight_col[r] = rd_q;
	end

endmodule

//--- rtl/matvec_sequencer.sv
// Control FSM of the multiplier: accepts weight and vector words, then issues
// one column read per cycle and waits for the result stream to finish
`timescale 1ns/1ps

module matvec_sequencer (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          input_valid,
	input  logic                          new_matrix,
	input  matvec_dims_pkg::data_t        input_data,
	output logic                          input_ready,
	input  logic                          results_done,
	output matvec_ctrl_pkg::store_write_t store_wr,
	output matvec_ctrl_pkg::column_read_t col_rd
);
	import matvec_dims_pkg::*;
	import matvec_ctrl_pkg::*;

	seq_state_t    state;
	seq_state_t    state_next;
	weight_index_u w_cnt;
	col_t          x_cnt;
	col_t          col_cnt;
	logic          accept;
	logic          to_weights;
	logic          w_last;
	logic          x_last;
	logic          col_last;

	// Open for input in every loading state
	assign input_ready = (state == IDLE) || (state == LOAD_W) || (state == LOAD_X);
	assign accept      = input_valid && input_ready;

	// new_matrix only matters on the first word of a load
	assign to_weights = (state == LOAD_W) || ((state == IDLE) && new_matrix);

	assign w_last   = (w_cnt.flat == N_ROWS * N_COLS - 1);
	assign x_last   = (x_cnt == col_t'(N_COLS - 1));
	assign col_last = (col_cnt == col_t'(N_COLS - 1));

	// Write strobe to both stores, each picks its own enable
	always_comb begin
		store_wr           = '0;
		store_wr.weight_we = accept && to_weights;
		store_wr.vector_we = accept && !to_weights;
		store_wr.data      = input_data;
		if (to_weights) begin
			store_wr.index = w_cnt;
		end else begin
			store_wr.index.flat = {row_t'(0), x_cnt};
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_next = new_matrix ? LOAD_W : LOAD_X;
				end
			end
			LOAD_W: begin
				if (accept && w_last) begin
					state_next = LOAD_X;
				end
			end
			LOAD_X: begin
				if (accept && x_last) begin
					state_next = COMPUTE;
				end
			end
			COMPUTE: begin
				if (col_last) begin
					state_next = DRAIN;
				end
			end
			DRAIN: begin
				// Output stream may be stalled for any length
				if (results_done) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	// Counters wrap back to zero at the end of each load
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			w_cnt   <= '0;
			x_cnt   <= '0;
			col_cnt <= '0;
		end else begin
			state <= state_next;
			if (store_wr.weight_we) begin
				w_cnt.flat <= w_cnt.flat + 1'b1;
			end
			if (store_wr.vector_we) begin
				x_cnt <= x_cnt + 1'b1;
			end
			if (state == COMPUTE) begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// Registered column read, one cycle behind the COMPUTE state
	always_ff @(posedge clk) begin
		if (reset) begin
			col_rd <= '0;
		end else begin
			col_rd.valid <= (state == COMPUTE);
			col_rd.first <= (state == COMPUTE) && (col_cnt == '0);
			col_rd.last  <= (state == COMPUTE) && col_last;
			col_rd.col   <= col_cnt;
		end
	end

endmodule

//--- rtl/matvec_ctrl_pkg.sv
// Sequencer states, multiplier depth and the control structs between blocks
// Used by the sequencer, the two stores and the MAC array
package matvec_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_W,
		LOAD_X,
		COMPUTE,
		DRAIN
	} seq_state_t;

	// Register stages in each lane multiplier
	localparam int MULT_STAGES = 3;

	// One input word on its way into a store
	typedef struct packed {
		logic                           weight_we;
		logic                           vector_we;
		matvec_dims_pkg::weight_index_u index;
		matvec_dims_pkg::data_t         data;
	} store_write_t;

	// Column read issued to both stores, flags travel on to the MACs
	typedef struct packed {
		logic                  valid;
		logic                  first;
		logic                  last;
		matvec_dims_pkg::col_t col;
	} column_read_t;

endpackage

//--- rtl/matvec_dims_pkg.sv
// Matrix sizes, data widths and data types shared by the multiplier datapath
// Imported by the stores, the MAC array and the sequencer
package matvec_dims_pkg;

	localparam int N_ROWS = 8;
	localparam int N_COLS = 8;

	localparam int DATA_W = 14;
	localparam int ACC_W  = 28;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0]  acc_t;

	// Saturation limits of the accumulator
	localparam acc_t ACC_MAX = {1'b0, {(ACC_W - 1){1'b1}}};
	localparam acc_t ACC_MIN = {1'b1, {(ACC_W - 1){1'b0}}};

	typedef logic [$clog2(N_COLS)-1:0] col_t;
	typedef logic [$clog2(N_ROWS)-1:0] row_t;

	// Row-major position of one weight word
	typedef struct packed {
		row_t row;
		col_t col;
	} weight_rc_t;

	// Flat word count for loading, row and column for the bank
	typedef union packed {
		logic [$bits(weight_rc_t)-1:0] flat;
		weight_rc_t                    rc;
	} weight_index_u;

endpackage
